/* include/rv_core_consts.svh */
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Data, address and instruction width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

// Address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

// Sequential PC increment, one instruction word
`define RV_PC_STEP 32'd4

// funct7 code that turns add into sub and srl into sra
`define RV_FUNCT7_ALT 7'b0100000

`endif

/* hdl/rv_core_pkg.sv */
`default_nettype none
`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;
    typedef logic [2:0] funct3_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_ARITH_R  = 7'b0110011,
        OP_ARITH_I  = 7'b0010011,
        OP_BRANCH   = 7'b1100011,
        OP_JAL      = 7'b1101111,
        OP_JALR     = 7'b1100111,
        OP_LOAD     = 7'b0000011,
        OP_STORE    = 7'b0100011,
        OP_LUI      = 7'b0110111,
        OP_AUIPC    = 7'b0010111,
        OP_MISC_MEM = 7'b0001111,  // fence, runs as a no-op
        OP_INVALID  = 7'b1111111
    } opcode_t;

    typedef enum logic [3:0] {
        CLASS_NONE,
        CLASS_ARITH_R,
        CLASS_ARITH_I,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_LUI,
        CLASS_AUIPC
    } instr_class_t;

    // Source of the value written to rd
    typedef enum logic [2:0] {
        WB_NONE,
        WB_ALU,
        WB_IMM,
        WB_PC_IMM,
        WB_PC_STEP,
        WB_LOAD
    } wb_sel_t;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_WAIT_FETCH,
        ST_EXECUTE,
        ST_WAIT_MEM
    } core_state_t;

endpackage

`default_nettype wire

/* hdl/rv_decoder.sv */
`default_nettype none
`include "rv_core_consts.svh"

module rv_decoder (
    input  wire rv_core_pkg::word_t      instr,
    output rv_core_pkg::reg_addr_t       rd,
    output rv_core_pkg::funct3_t         funct3,
    output logic                         alt,
    output rv_core_pkg::word_t           imm,
    output rv_core_pkg::instr_class_t    instr_class,
    output rv_core_pkg::wb_sel_t         wb_sel
);

    rv_core_pkg::opcode_t opcode;
    logic [6:0] funct7;
    logic sign;

    assign rd = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign sign = instr[31];

    // Unknown codes collapse onto OP_INVALID
    always_comb begin
        case (instr[6:0])
            rv_core_pkg::OP_ARITH_R:  opcode = rv_core_pkg::OP_ARITH_R;
            rv_core_pkg::OP_ARITH_I:  opcode = rv_core_pkg::OP_ARITH_I;
            rv_core_pkg::OP_BRANCH:   opcode = rv_core_pkg::OP_BRANCH;
            rv_core_pkg::OP_JAL:      opcode = rv_core_pkg::OP_JAL;
            rv_core_pkg::OP_JALR:     opcode = rv_core_pkg::OP_JALR;
            rv_core_pkg::OP_LOAD:     opcode = rv_core_pkg::OP_LOAD;
            rv_core_pkg::OP_STORE:    opcode = rv_core_pkg::OP_STORE;
            rv_core_pkg::OP_LUI:      opcode = rv_core_pkg::OP_LUI;
            rv_core_pkg::OP_AUIPC:    opcode = rv_core_pkg::OP_AUIPC;
            rv_core_pkg::OP_MISC_MEM: opcode = rv_core_pkg::OP_MISC_MEM;
            default:                  opcode = rv_core_pkg::OP_INVALID;
        endcase
    end

    // Fence and invalid opcodes leave the class at none, so they only step the PC
    always_comb begin
        case (opcode)
            rv_core_pkg::OP_ARITH_R: instr_class = rv_core_pkg::CLASS_ARITH_R;
            rv_core_pkg::OP_ARITH_I: instr_class = rv_core_pkg::CLASS_ARITH_I;
            rv_core_pkg::OP_BRANCH:  instr_class = rv_core_pkg::CLASS_BRANCH;
            rv_core_pkg::OP_JAL:     instr_class = rv_core_pkg::CLASS_JAL;
            rv_core_pkg::OP_JALR:    instr_class = rv_core_pkg::CLASS_JALR;
            rv_core_pkg::OP_LOAD:    instr_class = rv_core_pkg::CLASS_LOAD;
            rv_core_pkg::OP_STORE:   instr_class = rv_core_pkg::CLASS_STORE;
            rv_core_pkg::OP_LUI:     instr_class = rv_core_pkg::CLASS_LUI;
            rv_core_pkg::OP_AUIPC:   instr_class = rv_core_pkg::CLASS_AUIPC;
            default:                 instr_class = rv_core_pkg::CLASS_NONE;
        endcase
    end

    // Immediate format per class, always sign extended from bit 31
    always_comb begin
        case (instr_class)
            rv_core_pkg::CLASS_ARITH_I, rv_core_pkg::CLASS_JALR, rv_core_pkg::CLASS_LOAD:
                imm = {{21{sign}}, instr[30:20]};
            rv_core_pkg::CLASS_STORE:
                imm = {{21{sign}}, instr[30:25], instr[11:7]};
            rv_core_pkg::CLASS_BRANCH:
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_core_pkg::CLASS_LUI, rv_core_pkg::CLASS_AUIPC:
                imm = {instr[31:12], 12'h000};
            rv_core_pkg::CLASS_JAL:
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // addi has no subtract form, srai carries the alt code in its immediate
    assign alt = (funct7 == `RV_FUNCT7_ALT) &&
                 ((instr_class == rv_core_pkg::CLASS_ARITH_R) ||
                  (instr_class == rv_core_pkg::CLASS_ARITH_I && funct3 == 3'b101));

    always_comb begin
        case (instr_class)
            rv_core_pkg::CLASS_ARITH_R, rv_core_pkg::CLASS_ARITH_I:
                wb_sel = rv_core_pkg::WB_ALU;
            rv_core_pkg::CLASS_LUI:
                wb_sel = rv_core_pkg::WB_IMM;
            rv_core_pkg::CLASS_AUIPC:
                wb_sel = rv_core_pkg::WB_PC_IMM;
            rv_core_pkg::CLASS_JAL, rv_core_pkg::CLASS_JALR:
                wb_sel = rv_core_pkg::WB_PC_STEP;
            rv_core_pkg::CLASS_LOAD:
                wb_sel = rv_core_pkg::WB_LOAD;
            default:
                wb_sel = rv_core_pkg::WB_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`default_nettype none
`include "rv_core_consts.svh"

module rv_regfile (
    input  wire logic                   clk_in,
    input  wire logic                   reset_in,
    input  wire rv_core_pkg::reg_addr_t raddr_a,
    input  wire rv_core_pkg::reg_addr_t raddr_b,
    output rv_core_pkg::word_t          rdata_a,
    output rv_core_pkg::word_t          rdata_b,
    input  wire logic                   we,
    input  wire rv_core_pkg::reg_addr_t waddr,
    input  wire rv_core_pkg::word_t     wdata
);

    rv_core_pkg::word_t regs [`RV_REG_COUNT];

    // Asynchronous read ports
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 keeps zero through any sequence of writes
    x0_reads_zero: assert property (@(posedge clk_in) disable iff (!reset_in)
        regs[0] == '0);

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`default_nettype none
`include "rv_core_consts.svh"

module rv_alu (
    input  wire rv_core_pkg::word_t   op_a,
    input  wire rv_core_pkg::word_t   op_b,
    input  wire rv_core_pkg::funct3_t funct3,
    input  wire logic                 alt,
    input  wire logic                 is_branch,
    output rv_core_pkg::word_t        result,
    output logic                      branch_taken
);

    localparam int MSB = `RV_XLEN - 1;

    logic [4:0] shamt;
    logic borrow;
    rv_core_pkg::word_t diff;
    logic zero;
    logic overflow;
    logic less_signed;
    logic cond;

    assign shamt = op_b[4:0];

    // Shared subtractor, the borrow doubles as the unsigned less-than flag
    assign {borrow, diff} = {1'b0, op_a} - {1'b0, op_b};
    assign zero = (diff == '0);
    assign overflow = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);
    assign less_signed = diff[MSB] ^ overflow;

    always_comb begin
        case (funct3)
            3'b000:  result = alt ? diff : op_a + op_b;
            3'b001:  result = op_a << shamt;
            3'b010:  result = rv_core_pkg::word_t'(less_signed);
            3'b011:  result = rv_core_pkg::word_t'(borrow);
            3'b100:  result = op_a ^ op_b;
            3'b101: begin
                if (alt) begin
                    result = rv_core_pkg::word_t'($signed(op_a) >>> shamt);
                end else begin
                    result = op_a >> shamt;
                end
            end
            3'b110:  result = op_a | op_b;
            default: result = op_a & op_b;
        endcase
    end

    // Branch funct3 codes, 010 and 011 are not used
    always_comb begin
        case (funct3)
            3'b000:  cond = zero;
            3'b001:  cond = !zero;
            3'b100:  cond = less_signed;
            3'b101:  cond = !less_signed;
            3'b110:  cond = borrow;
            3'b111:  cond = !borrow;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = is_branch && cond;

endmodule

`default_nettype wire

/* hdl/rv_control.sv */
`default_nettype none
`include "rv_core_consts.svh"

module rv_control (
    input  wire logic                      clk_in,
    input  wire logic                      reset_in,
    output logic                           mem_req,
    output logic                           mem_we,
    output rv_core_pkg::word_t             mem_addr,
    output rv_core_pkg::word_t             mem_wdata,
    input  wire rv_core_pkg::word_t        mem_rdata,
    input  wire logic                      mem_ack,
    output rv_core_pkg::word_t             instr,
    output rv_core_pkg::reg_addr_t         raddr_a,
    output rv_core_pkg::reg_addr_t         raddr_b,
    input  wire rv_core_pkg::word_t        rs1_data,
    input  wire rv_core_pkg::word_t        rs2_data,
    input  wire rv_core_pkg::reg_addr_t    rd,
    input  wire rv_core_pkg::word_t        imm,
    input  wire rv_core_pkg::instr_class_t instr_class,
    input  wire rv_core_pkg::wb_sel_t      wb_sel,
    output rv_core_pkg::word_t             alu_a,
    output rv_core_pkg::word_t             alu_b,
    input  wire rv_core_pkg::word_t        alu_result,
    input  wire logic                      branch_taken,
    output logic                           reg_we,
    output rv_core_pkg::reg_addr_t         reg_waddr,
    output rv_core_pkg::word_t             reg_wdata
);

    rv_core_pkg::core_state_t state;
    rv_core_pkg::word_t pc;
    rv_core_pkg::word_t pc_next;
    rv_core_pkg::word_t pc_plus_imm;
    rv_core_pkg::word_t pc_plus_step;
    rv_core_pkg::word_t rs1_plus_imm;
    rv_core_pkg::word_t rs1_q;
    rv_core_pkg::word_t rs2_q;
    rv_core_pkg::word_t addr;
    logic is_mem;
    logic is_store;
    logic fetch_done;
    logic retire;

    // Source fields come straight off the bus so the operands are ready with the instruction
    assign raddr_a = mem_rdata[19:15];
    assign raddr_b = mem_rdata[24:20];

    assign is_store = (instr_class == rv_core_pkg::CLASS_STORE);
    assign is_mem = is_store || (instr_class == rv_core_pkg::CLASS_LOAD);

    assign pc_plus_imm = pc + imm;
    assign pc_plus_step = pc + `RV_PC_STEP;
    assign rs1_plus_imm = rs1_q + imm;

    // Register ops and compares take rs2, everything else the immediate
    assign alu_a = rs1_q;
    assign alu_b = (instr_class == rv_core_pkg::CLASS_ARITH_R ||
                    instr_class == rv_core_pkg::CLASS_BRANCH) ? rs2_q : imm;

    always_comb begin
        case (instr_class)
            rv_core_pkg::CLASS_JAL:    pc_next = pc_plus_imm;
            rv_core_pkg::CLASS_JALR:   pc_next = {rs1_plus_imm[`RV_XLEN-1:1], 1'b0};
            rv_core_pkg::CLASS_BRANCH: pc_next = branch_taken ? pc_plus_imm : pc_plus_step;
            default:                   pc_next = pc_plus_step;
        endcase
    end

    // PC until the instruction arrives, then the effective address
    assign addr = (state == rv_core_pkg::ST_FETCH || state == rv_core_pkg::ST_WAIT_FETCH) ?
                  pc : rs1_plus_imm;
    assign mem_addr = {addr[`RV_XLEN-1:2], 2'b00};
    assign mem_wdata = rs2_q;

    assign mem_req = (state == rv_core_pkg::ST_FETCH) ||
                     (state == rv_core_pkg::ST_EXECUTE && is_mem);
    // Held through the wait so the store stays stable until its ack
    assign mem_we = is_store && (state == rv_core_pkg::ST_EXECUTE ||
                                 state == rv_core_pkg::ST_WAIT_MEM);

    assign fetch_done = (state == rv_core_pkg::ST_WAIT_FETCH) && mem_ack;
    assign retire = (state == rv_core_pkg::ST_EXECUTE && !is_mem) ||
                    (state == rv_core_pkg::ST_WAIT_MEM && mem_ack);

    assign reg_we = retire && (wb_sel != rv_core_pkg::WB_NONE);
    assign reg_waddr = rd;

    always_comb begin
        case (wb_sel)
            rv_core_pkg::WB_ALU:     reg_wdata = alu_result;
            rv_core_pkg::WB_IMM:     reg_wdata = imm;
            rv_core_pkg::WB_PC_IMM:  reg_wdata = pc_plus_imm;
            rv_core_pkg::WB_PC_STEP: reg_wdata = pc_plus_step;
            rv_core_pkg::WB_LOAD:    reg_wdata = mem_rdata;
            default:                 reg_wdata = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            state <= rv_core_pkg::ST_FETCH;
            pc <= `RV_RESET_PC;
        end else begin
            case (state)
                rv_core_pkg::ST_FETCH: begin
                    state <= rv_core_pkg::ST_WAIT_FETCH;
                end
                rv_core_pkg::ST_WAIT_FETCH: begin
                    if (mem_ack) begin
                        state <= rv_core_pkg::ST_EXECUTE;
                    end
                end
                rv_core_pkg::ST_EXECUTE: begin
                    state <= is_mem ? rv_core_pkg::ST_WAIT_MEM : rv_core_pkg::ST_FETCH;
                end
                default: begin
                    if (mem_ack) begin
                        state <= rv_core_pkg::ST_FETCH;
                    end
                end
            endcase
            if (retire) begin
                pc <= pc_next;
            end
        end
    end

    // Instruction and both operands are captured on the fetch ack
    always_ff @(posedge clk_in) begin
        if (fetch_done) begin
            instr <= mem_rdata;
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
        end
    end

    // A request is issued from fetch or execute and lasts one cycle
    req_single_cycle: assert property (@(posedge clk_in) disable iff (!reset_in)
        mem_req |-> (state == rv_core_pkg::ST_FETCH || state == rv_core_pkg::ST_EXECUTE)
                    ##1 !mem_req);

    // The memory only answers an outstanding request
    ack_while_waiting: assert property (@(posedge clk_in) disable iff (!reset_in)
        mem_ack |-> (state == rv_core_pkg::ST_WAIT_FETCH || state == rv_core_pkg::ST_WAIT_MEM));

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`default_nettype none

module rv_core (
    input  wire logic               clk_in,
    input  wire logic               reset_in,
    output logic                    mem_req,
    output logic                    mem_we,
    output rv_core_pkg::word_t      mem_addr,
    output rv_core_pkg::word_t      mem_wdata,
    input  wire rv_core_pkg::word_t mem_rdata,
    input  wire logic               mem_ack
);

    rv_core_pkg::word_t instr;
    rv_core_pkg::reg_addr_t raddr_a;
    rv_core_pkg::reg_addr_t raddr_b;
    rv_core_pkg::word_t rs1_data;
    rv_core_pkg::word_t rs2_data;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::funct3_t funct3;
    logic alt;
    rv_core_pkg::word_t imm;
    rv_core_pkg::instr_class_t instr_class;
    rv_core_pkg::wb_sel_t wb_sel;
    rv_core_pkg::word_t alu_a;
    rv_core_pkg::word_t alu_b;
    rv_core_pkg::word_t alu_result;
    logic alu_is_branch;
    logic branch_taken;
    logic reg_we;
    rv_core_pkg::reg_addr_t reg_waddr;
    rv_core_pkg::word_t reg_wdata;

    // Compare mode of the ALU follows the decoded class
    assign alu_is_branch = (instr_class == rv_core_pkg::CLASS_BRANCH);

    rv_control u_control (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_ack      (mem_ack),
        .instr        (instr),
        .raddr_a      (raddr_a),
        .raddr_b      (raddr_b),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd           (rd),
        .imm          (imm),
        .instr_class  (instr_class),
        .wb_sel       (wb_sel),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .reg_we       (reg_we),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata)
    );

    rv_decoder u_decoder (
        .instr       (instr),
        .rd          (rd),
        .funct3      (funct3),
        .alt         (alt),
        .imm         (imm),
        .instr_class (instr_class),
        .wb_sel      (wb_sel)
    );

    rv_regfile u_regfile (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .raddr_a  (raddr_a),
        .raddr_b  (raddr_b),
        .rdata_a  (rs1_data),
        .rdata_b  (rs2_data),
        .we       (reg_we),
        .waddr    (reg_waddr),
        .wdata    (reg_wdata)
    );

    rv_alu u_alu (
        .op_a         (alu_a),
        .op_b         (alu_b),
        .funct3       (funct3),
        .alt          (alt),
        .is_branch    (alu_is_branch),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

/* verif/rv_core_tb.sv */
`default_nettype none
`include "rv_core_consts.svh"

module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 1024;
    localparam int MAX_STEPS = 4096;
    // Request, four wait cycles, execute, four more for a data access, plus margin
    localparam int WORST_CPI = 12;
    localparam logic [6:0] OP_R = 7'b0110011;
    localparam logic [6:0] OP_I = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    logic clk_in;
    logic reset_in;
    logic mem_req;
    logic mem_we;
    rv_core_pkg::word_t mem_addr;
    rv_core_pkg::word_t mem_wdata;
    rv_core_pkg::word_t mem_rdata;
    logic mem_ack;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] lcg_state;
    logic [31:0] halt_pc;
    int wr_ptr;
    int ref_instr_count;
    int errors;
    int checks;
    logic run_done;
    logic outstanding;

    // Expected bus accesses in order, fetches and loads carry no data
    logic exp_we [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    // Memory model state
    int wait_count;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic req_we;

    rv_core u_rv_core (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                          int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_R};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] imm, int rs1, logic [2:0] f3, int rd,
                                          logic [6:0] op);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [31:0] imm, int rd, logic [6:0] op);
        return {imm[19:0], 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic void emit(logic [31:0] word);
        mem[wr_ptr] = word;
        wr_ptr++;
    endfunction

    // lui plus addi, the upper part rounded for the sign of the low twelve bits
    function automatic void load_const(int rd, logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(enc_u({12'b0, upper[31:12]}, rd, OP_LUI));
        emit(enc_i(value, rd, 3'b000, rd, OP_I));
    endfunction

    function automatic void build_program();
        logic [31:0] r;
        logic [31:0] imm;
        logic [2:0] f3;
        logic [31:0] pa [5];
        logic [31:0] pb [5];
        wr_ptr = `RV_RESET_PC >> 2;
        for (int i = 1; i < 16; i++) begin
            load_const(i, lcg_next());
        end
        for (int k = 0; k < 24; k++) begin
            r = lcg_next();
            f3 = r[2:0];
            if (r[3]) begin
                imm = (r[4] && (f3 == 3'b000 || f3 == 3'b101)) ? `RV_FUNCT7_ALT : 7'b0;
                emit(enc_r(imm[6:0], int'(r[19:16]), int'(r[15:12]), f3, int'(r[11:8] % 15) + 1));
            end else begin
                if (f3 == 3'b001) begin
                    imm = {27'b0, r[24:20]};
                end else if (f3 == 3'b101) begin
                    imm = {20'b0, (r[4] ? `RV_FUNCT7_ALT : 7'b0), r[24:20]};
                end else begin
                    imm = {{20{r[31]}}, r[31:20]};
                end
                emit(enc_i(imm, int'(r[15:12]), f3, int'(r[11:8] % 15) + 1, OP_I));
            end
        end
        // Subtract and every shift form at least once
        emit(enc_r(`RV_FUNCT7_ALT, 2, 1, 3'b000, 16));
        emit(enc_r(7'b0, 4, 3, 3'b001, 17));
        emit(enc_r(7'b0, 6, 5, 3'b101, 18));
        emit(enc_r(`RV_FUNCT7_ALT, 8, 7, 3'b101, 19));
        emit(enc_i({20'b0, `RV_FUNCT7_ALT, 5'd7}, 9, 3'b101, 20, OP_I));
        emit(enc_i(32'd13, 10, 3'b001, 21, OP_I));
        emit(enc_i(32'd29, 11, 3'b101, 22, OP_I));
        for (int i = 1; i < 32; i++) begin
            emit(enc_s(32'h600 + 4 * i, i, 0));
        end
        // Equal, signed negative and unsigned large operand pairs, both orders
        pa = '{32'd5, 32'hFFFF_FFFD, 32'd7, 32'hF000_0000, 32'd1};
        pb = '{32'd5, 32'd7, 32'hFFFF_FFFD, 32'd1, 32'hF000_0000};
        for (int p = 0; p < 5; p++) begin
            load_const(21, pa[p]);
            load_const(22, pb[p]);
            for (int c = 0; c < 8; c++) begin
                if (c == 2 || c == 3) begin
                    continue;
                end
                emit(enc_i(32'd0, 0, 3'b000, 20, OP_I));
                emit(enc_b(32'd8, 22, 21, 3'(c)));
                emit(enc_i(32'd1, 0, 3'b000, 20, OP_I));
                emit(enc_s(32'h700, 20, 0));
            end
        end
        emit(enc_j(32'd8, 24));
        emit(enc_i(32'd99, 0, 3'b000, 25, OP_I));
        emit(enc_u(32'h1, 26, OP_AUIPC));
        emit(enc_u(32'h0, 27, OP_AUIPC));
        // Odd offset, bit zero of the target is dropped
        emit(enc_i(32'd13, 27, 3'b000, 28, OP_JALR));
        emit(enc_i(32'd77, 0, 3'b000, 25, OP_I));
        emit(enc_s(32'h704, 24, 0));
        emit(enc_s(32'h708, 25, 0));
        emit(enc_s(32'h70C, 26, 0));
        emit(enc_s(32'h710, 28, 0));
        emit(enc_i(32'd55, 0, 3'b000, 0, OP_I));
        emit(enc_u(32'h12345, 0, OP_LUI));
        emit(enc_j(32'd4, 0));
        emit(enc_s(32'h714, 0, 0));
        emit(enc_r(7'b0, 0, 0, 3'b000, 29));
        emit(enc_s(32'h718, 29, 0));
        emit(32'h0000_000b);
        // Read, modify and write back through a base register
        load_const(7, 32'h790);
        emit(enc_i(-32'sd4, 7, 3'b010, 8, OP_LOAD));
        emit(enc_i(32'h123, 8, 3'b000, 8, OP_I));
        emit(enc_i(32'hFFF, 8, 3'b100, 8, OP_I));
        emit(enc_s(32'd4, 8, 7));
        emit(enc_i(32'd4, 7, 3'b010, 9, OP_LOAD));
        emit(enc_r(7'b0, 8, 9, 3'b000, 9));
        emit(enc_s(32'h798, 9, 0));
        emit(enc_i(32'd2, 7, 3'b010, 10, OP_LOAD));
        emit(enc_s(32'h79C, 10, 0));
        halt_pc = wr_ptr * 4;
        emit(enc_j(32'd0, 0));
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic void push_expected(logic we, logic [31:0] addr, logic [31:0] data);
        exp_we.push_back(we);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endfunction

    // Runs the program on its own state up to the halt loop
    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] addr;
        logic [2:0] f3;
        logic wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = `RV_RESET_PC;
        for (int step = 0; step < MAX_STEPS; step++) begin
            instr = ref_mem[pc[11:2]];
            push_expected(1'b0, pc, '0);
            ref_instr_count++;
            if (pc == halt_pc) begin
                break;
            end
            a = regs[instr[19:15]];
            b = regs[instr[24:20]];
            f3 = instr[14:12];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            next_pc = pc + `RV_PC_STEP;
            wr = 1'b1;
            res = '0;
            case (instr[6:0])
                OP_R: res = alu_ref(f3, instr[30], a, b);
                OP_I: res = alu_ref(f3, instr[30] && f3 == 3'b101, a, imm_i);
                OP_LUI: res = {instr[31:12], 12'h000};
                OP_AUIPC: res = pc + {instr[31:12], 12'h000};
                OP_JAL: begin
                    res = pc + `RV_PC_STEP;
                    next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                end
                OP_JALR: begin
                    res = pc + `RV_PC_STEP;
                    next_pc = (a + imm_i) & ~32'h1;
                end
                OP_BRANCH: begin
                    wr = 1'b0;
                    if (branch_ref(f3, a, b)) begin
                        next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                    end
                end
                OP_LOAD: begin
                    addr = (a + imm_i) & ~32'h3;
                    push_expected(1'b0, addr, '0);
                    res = ref_mem[addr[11:2]];
                end
                OP_STORE: begin
                    wr = 1'b0;
                    addr = (a + {{20{instr[31]}}, instr[31:25], instr[11:7]}) & ~32'h3;
                    push_expected(1'b1, addr, b);
                    ref_mem[addr[11:2]] = b;
                end
                default: wr = 1'b0;
            endcase
            if (wr && instr[11:7] != 5'd0) begin
                regs[instr[11:7]] = res;
            end
            pc = next_pc;
        end
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // Takes each request at the clock edge that closes its cycle
    always @(posedge clk_in) begin : accept_request
        if (reset_in && mem_req && wait_count == 0) begin
            req_addr = mem_addr;
            req_we = mem_we;
            req_wdata = mem_wdata;
            wait_count = 1 + int'(lcg_next() % 4);
        end
    end

    // Answers each request 1 to 4 cycles later
    always @(negedge clk_in) begin : answer_request
        mem_ack = 1'b0;
        if (wait_count > 0) begin
            wait_count = wait_count - 1;
            if (wait_count == 0) begin
                mem_ack = 1'b1;
                if (req_we) begin
                    mem[req_addr[11:2]] = req_wdata;
                end else begin
                    mem_rdata = mem[req_addr[11:2]];
                end
            end
        end
    end

    always @(posedge clk_in) begin : compare_requests
        logic we_exp;
        logic [31:0] data_exp;
        if (reset_in && !run_done) begin
            if (mem_req) begin
                if (outstanding) begin
                    $display("Request issued while another one is still outstanding");
                    errors++;
                end
                outstanding = 1'b1;
                if (exp_addr.size() == 0) begin
                    $display("Request issued beyond the end of the expected sequence");
                    errors++;
                end else begin
                    we_exp = exp_we.pop_front();
                    data_exp = exp_data.pop_front();
                    check_value("mem_we", {31'b0, mem_we}, {31'b0, we_exp});
                    check_value("mem_addr", mem_addr, exp_addr.pop_front());
                    if (we_exp) begin
                        check_value("mem_wdata", mem_wdata, data_exp);
                    end
                    run_done = (exp_addr.size() == 0);
                end
            end
            if (mem_ack) begin
                outstanding = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int missing;
        wait (ref_instr_count > 0);
        repeat (ref_instr_count * WORST_CPI * 2) @(posedge clk_in);
        missing = 0;
        foreach (exp_we[i]) begin
            missing += exp_we[i];
        end
        $display("Timeout: the core did not reach the halt loop in time");
        if (missing > 0) begin
            $display("Fewer stores than expected, %0d still missing", missing);
        end
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk_in = 1'b0;
        reset_in = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        lcg_state = 32'h19b1;
        errors = 0;
        checks = 0;
        run_done = 1'b0;
        outstanding = 1'b0;
        wait_count = 0;
        ref_instr_count = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'h9E37_79B9 * i) ^ (i << 11);
        end
        build_program();
        ref_mem = mem;
        run_reference();
        repeat (5) @(negedge clk_in);
        reset_in = 1'b1;
        wait (run_done);
        @(negedge clk_in);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_control.sv
hdl/rv_core.sv
verif/rv_core_tb.sv
